// ==== Makefile ====
VERILATOR  ?= verilator
FLIST      := flist.f
TOP        := tb_st_glue
RTL_TOP    := st_glue
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
+incdir+include
verilog/st_glue_pkg.sv
verilog/sd_request_arbiter.sv
verilog/boot_control.sv
verilog/input_mapper.sv
verilog/audio_volume.sv
verilog/st_glue.sv
verification/tb_st_glue.sv

// ==== include/st_glue_defs.svh ====
`ifndef ST_GLUE_DEFS_SVH
`define ST_GLUE_DEFS_SVH

// sd card sector interface
`define ST_LBA_W 32 // sector number width

// ram word address, bits 23:1
// bit 23 splits the ram window from the rest of the map
`define ST_RAM_AW 23

// keyboard matrix as seen by the ikbd
// one active low select per row
`define ST_KBD_ROWS 15

// chipset audio mix width, signed
`define ST_AUDIO_IN_W 15

// how long boot waits for the mcu to mount an sd image
// 2 s at 32 MHz
`define ST_SD_WAIT_CYCLES 64000000

`endif

// ==== verification/tb_st_glue.sv ====
`timescale 1ns/1ns
`include "st_glue_defs.svh"

module tb_st_glue import st_glue_pkg::*; ();

  localparam int wait_cycles = 40; // short sd wait for simulation
  localparam int cycle_limit = 4000; // all tests with margin

  logic clk32;
  logic rst;
  req_pair_t fdc_rd, fdc_wr, acsi_rd, acsi_wr;
  lba_t fdc_lba, acsi_lba, sd_lba;
  sd_byte_t fdc_wr_byte, acsi_wr_byte, sd_wr_byte;
  logic [3:0] sd_rstart, sd_wstart;
  logic reset_req, coldboot, user_reset, ram_ready, flash_ready, ram_ras_n;
  logic [31:0] sd_img_size;
  ram_addr_t ram_addr;
  logic core_run, sd_ready, ram_cs;
  logic [`ST_RAM_AW-1:1] ram_addr_s;
  logic [7:0] io, hid_joy;
  mouse_port_t mouse_port;
  joy_t hid_mouse, joy0, db9_joy;
  key_row_t keyboard [`ST_KBD_ROWS];
  logic [`ST_KBD_ROWS-1:0] kbd_col_sel;
  logic [4:0] joy1;
  key_row_t kbd_rows;
  volume_t volume;
  sample_in_t audio_l_in, audio_r_in;
  sample_t audio_l, audio_r;

  logic [31:0] rng_state = 32'd1; // xorshift seed
  int cycles = 0;

  st_glue #(.sd_wait_cycles(wait_cycles)) DUT (.*);

  initial begin
    clk32 = 1'b0;
    forever #50 clk32 = ~clk32; // 100 ns period
  end

  // run limit
  always @(posedge clk32) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout, the run went past %0d clock cycles", cycle_limit);
      stop_run();
    end
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_lba(input string name, input lba_t exp, input lba_t act);
    if (act !== exp) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask
  task automatic check_byte(input string name, input sd_byte_t exp, input sd_byte_t act);
    if (act !== exp) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask
  task automatic check_req(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
      $display("mismatch %s expected %b actual %b", name, exp, act);
      stop_run();
    end
  endtask
  task automatic check_addr(input string name, input logic [`ST_RAM_AW-1:1] exp,
                            input logic [`ST_RAM_AW-1:1] act);
    if (act !== exp) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask
  task automatic check_joy(input string name, input joy_t exp, input joy_t act);
    if (act !== exp) begin
      $display("mismatch %s expected %b actual %b", name, exp, act);
      stop_run();
    end
  endtask
  task automatic check_row(input string name, input key_row_t exp, input key_row_t act);
    if (act !== exp) begin
      $display("mismatch %s expected %b actual %b", name, exp, act);
      stop_run();
    end
  endtask
  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      $display("mismatch %s expected %0d actual %0d", name, exp, act);
      stop_run();
    end
  endtask
  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s expected %b actual %b", name, exp, act);
      stop_run();
    end
  endtask

  // db9 pins to fire2, fire, up, down, left, right
  function automatic joy_t decode_db9(input logic [7:0] pins, input logic amiga);
    joy_t j;
    j[5] = ~pins[5];
    j[4] = ~pins[0];
    j[3] = amiga ? ~pins[3] : ~pins[2]; // up swaps with right on amiga
    j[2] = ~pins[1];
    j[1] = ~pins[4];
    j[0] = amiga ? ~pins[2] : ~pins[3];
    return j;
  endfunction

  // signed divide rounding toward minus infinity
  function automatic sample_t scaled_sample(input sample_in_t s, input volume_t v);
    int x;
    int d;
    x = int'(s);
    d = (v == vol_quarter) ? 4 : (v == vol_half) ? 2 : 1;
    if (v == vol_mute) return '0;
    if (x >= 0) return sample_t'(x / d);
    return sample_t'(-((-x + d - 1) / d));
  endfunction

  task automatic do_reset(input logic [31:0] img);
    @(posedge clk32);
    rst <= 1'b1;
    sd_img_size <= img;
    repeat (2) @(posedge clk32);
    rst <= 1'b0; // flops still see reset on this edge
  endtask

  task automatic run_boot();
    logic [31:0] rnd;
    logic exp_run;
    do_reset(32'd0); // no image, wait runs out
    @(negedge clk32);
    check_bit("core run after reset", 1'b0, core_run);
    for (int i = 1; i <= wait_cycles + 1; i++) begin
      @(posedge clk32);
      @(negedge clk32);
      check_bit("sd ready on wait limit", i == wait_cycles + 1, sd_ready);
    end
    do_reset(next_random() | 32'd1); // image already mounted
    @(negedge clk32);
    check_bit("sd ready in reset", 1'b0, sd_ready);
    @(posedge clk32);
    @(negedge clk32);
    check_bit("sd ready with image", 1'b1, sd_ready);
    repeat (60) begin
      @(posedge clk32);
      rnd = next_random();
      ram_ready <= |rnd[1:0];
      flash_ready <= |rnd[3:2];
      user_reset <= &rnd[5:4];
      reset_req <= &rnd[7:6];
      exp_run = (|rnd[1:0]) && (|rnd[3:2]) && !(&rnd[5:4]) && !(&rnd[7:6]);
      @(negedge clk32);
      check_bit("core run", exp_run, core_run);
    end
  endtask

  task automatic run_scramble();
    logic [31:0] rnd;
    logic cb_applied, cb_seen;
    logic [1:0] edges; // cold boot rising edges mod 4
    ram_addr_t addr;
    logic [`ST_RAM_AW-1:1] exp_addr;
    cb_applied = 1'b0;
    cb_seen = 1'b0;
    edges = 2'd0;
    repeat (200) begin
      @(posedge clk32);
      if (cb_applied && !cb_seen) edges = edges + 2'd1; // dut sees last level now
      cb_seen = cb_applied;
      rnd = next_random();
      addr = rnd[22:0];
      cb_applied = rnd[31];
      coldboot <= rnd[31];
      ram_addr <= addr;
      ram_ras_n <= rnd[30];
      exp_addr = addr[`ST_RAM_AW-1:1] ^ {{(`ST_RAM_AW-5){1'b0}}, edges, 2'b00};
      @(negedge clk32);
      check_addr("scrambled address", exp_addr, ram_addr_s);
      check_bit("ram select", !rnd[30] && !addr[`ST_RAM_AW], ram_cs);
    end
  endtask

  task automatic run_arbitration();
    logic [31:0] rnd;
    req_pair_t f_rd, f_wr, a_rd, a_wr;
    lba_t f_lba, a_lba;
    sd_byte_t f_b, a_b;
    logic f_seen, a_seen, owner;
    owner = 1'b0;
    f_seen = 1'b0;
    a_seen = 1'b0;
    repeat (300) begin
      @(posedge clk32);
      if (f_seen) owner = 1'b0; // floppy takes a tie
      else if (a_seen) owner = 1'b1;
      rnd = next_random();
      f_rd = (rnd[3:0] == 4'd0) ? rnd[5:4] : 2'b00; // sparse levels
      f_wr = (rnd[9:6] == 4'd0) ? rnd[11:10] : 2'b00;
      a_rd = (rnd[15:12] == 4'd0) ? rnd[17:16] : 2'b00;
      a_wr = (rnd[21:18] == 4'd0) ? rnd[23:22] : 2'b00;
      f_lba = next_random();
      a_lba = next_random();
      rnd = next_random();
      f_b = rnd[7:0];
      a_b = rnd[15:8];
      fdc_rd <= f_rd;
      fdc_wr <= f_wr;
      acsi_rd <= a_rd;
      acsi_wr <= a_wr;
      fdc_lba <= f_lba;
      acsi_lba <= a_lba;
      fdc_wr_byte <= f_b;
      acsi_wr_byte <= a_b;
      f_seen = |{f_rd, f_wr};
      a_seen = |{a_rd, a_wr};
      @(negedge clk32);
      check_lba("sector number", (a_seen || owner) ? a_lba : f_lba, sd_lba);
      check_byte("write byte", (a_seen || owner) ? a_b : f_b, sd_wr_byte);
      check_req("read starts", {a_rd, f_rd}, sd_rstart);
      check_req("write starts", {a_wr, f_wr}, sd_wstart);
    end
  endtask

  task automatic run_ports();
    logic [31:0] rnd;
    mouse_port_t mp;
    joy_t atari, amiga, exp0, exp_db9;
    logic [4:0] exp1;
    for (int i = 0; i < 120; i++) begin
      @(posedge clk32);
      rnd = next_random();
      mp = mouse_port_t'(i[1:0]); // all four settings in turn
      mouse_port <= mp;
      io <= rnd[7:0];
      hid_mouse <= rnd[13:8];
      hid_joy <= rnd[21:14];
      atari = decode_db9(rnd[7:0], 1'b0);
      amiga = decode_db9(rnd[7:0], 1'b1);
      if (mp == port_usb) exp0 = rnd[13:8];
      else if (mp == port_atari) exp0 = atari;
      else if (mp == port_amiga) exp0 = amiga;
      else exp0 = '0;
      exp_db9 = (mp == port_usb) ? atari : '0;
      exp1 = rnd[18:14] | exp_db9[4:0];
      @(negedge clk32);
      check_joy("mouse port", exp0, joy0);
      check_joy("db9 joystick", exp_db9, db9_joy);
      check_joy("joystick port", {1'b0, exp1}, {1'b0, joy1});
    end
  endtask

  task automatic run_keyboard();
    logic [31:0] rnd;
    key_row_t rows [`ST_KBD_ROWS];
    logic [`ST_KBD_ROWS-1:0] sel;
    key_row_t exp;
    for (int i = 0; i < 90; i++) begin
      @(posedge clk32);
      for (int k = 0; k < `ST_KBD_ROWS; k++) begin
        rnd = next_random();
        rows[k] = rnd[7:0] | rnd[15:8] | rnd[23:16]; // few keys down
        keyboard[k] <= rows[k];
      end
      rnd = next_random();
      sel = '1;
      case (i % 3)
        0: sel = '1; // nothing selected
        1: sel[rnd[7:0] % `ST_KBD_ROWS] = 1'b0; // one row
        default: sel = rnd[`ST_KBD_ROWS-1:0];
      endcase
      kbd_col_sel <= sel;
      exp = '1;
      for (int b = 0; b < 8; b++) begin
        for (int k = 0; k < `ST_KBD_ROWS; k++) begin
          if (!sel[k] && !rows[k][b]) exp[b] = 1'b0; // any selected key pulls low
        end
      end
      @(negedge clk32);
      check_row("keyboard rows", exp, kbd_rows);
    end
  endtask

  task automatic run_volume();
    logic [31:0] rnd;
    sample_in_t s_l, s_r;
    volume_t vol;
    for (int v = 0; v < 4; v++) begin
      vol = volume_t'(v[1:0]);
      for (int i = 0; i < 40; i++) begin
        @(posedge clk32);
        rnd = next_random();
        case (i)
          0: begin
            s_l = 15'h4000; // most negative, most positive
            s_r = 15'h3fff;
          end
          1: begin
            s_l = 15'h3fff;
            s_r = 15'h4000;
          end
          2: begin
            s_l = 15'h7fff; // -1 and zero
            s_r = 15'h0000;
          end
          default: begin
            s_l = rnd[14:0];
            s_r = rnd[30:16];
          end
        endcase
        volume <= vol;
        audio_l_in <= s_l;
        audio_r_in <= s_r;
        @(negedge clk32);
        check_sample("left channel", scaled_sample(s_l, vol), audio_l);
        check_sample("right channel", scaled_sample(s_r, vol), audio_r);
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    fdc_rd = '0;
    fdc_wr = '0;
    acsi_rd = '0;
    acsi_wr = '0;
    fdc_lba = '0;
    acsi_lba = '0;
    fdc_wr_byte = '0;
    acsi_wr_byte = '0;
    reset_req = 1'b0;
    coldboot = 1'b0;
    user_reset = 1'b0;
    ram_ready = 1'b1;
    flash_ready = 1'b1;
    sd_img_size = '0;
    ram_addr = '0;
    ram_ras_n = 1'b1;
    io = '1; // db9 idle high
    mouse_port = port_usb;
    hid_mouse = '0;
    hid_joy = '0;
    for (int k = 0; k < `ST_KBD_ROWS; k++) keyboard[k] = '1;
    kbd_col_sel = '1;
    volume = vol_full;
    audio_l_in = '0;
    audio_r_in = '0;
    run_boot();
    run_scramble();
    run_arbitration();
    run_ports();
    run_keyboard();
    run_volume();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== verilog/audio_volume.sv ====
`timescale 1ns/1ns

// chipset mix to 16 bit dac samples with the osd volume applied
module audio_volume import st_glue_pkg::*; (
  input  volume_t    volume,
  input  sample_in_t audio_l_in,
  input  sample_in_t audio_r_in,
  output sample_t    audio_l,
  output sample_t    audio_r
);

  // volume by signed division, shifts keep the sign
  function automatic sample_t scale(sample_in_t s, volume_t v);
    sample_t wide;
    wide = sample_t'(s); // sign extend
    case (v)
      vol_mute:    scale = '0;
      vol_quarter: scale = wide >>> 2;
      vol_half:    scale = wide >>> 1;
      default:     scale = wide; // full
    endcase
  endfunction

  assign audio_l = scale(audio_l_in, volume);
  assign audio_r = scale(audio_r_in, volume);

endmodule

// ==== verilog/boot_control.sv ====
`timescale 1ns/1ns
`include "st_glue_defs.svh"

// holds the st in reset until ram, flash and sd image are usable
// also scrambles the ram on cold boot so old contents look invalid
module boot_control import st_glue_pkg::*; #(
  parameter int unsigned sd_wait_cycles = `ST_SD_WAIT_CYCLES // max wait for sd image
) (
  input  logic       clk32,
  input  logic       rst,
  input  logic       reset_req, // osd reset
  input  logic       coldboot, // osd cold boot flag, level
  input  logic       user_reset, // reset button
  input  logic       ram_ready,
  input  logic       flash_ready,
  input  logic [31:0] sd_img_size, // nonzero once an image is mounted
  input  ram_addr_t  ram_addr,
  input  logic       ram_ras_n,
  output logic       core_run, // release of the st reset
  output logic       sd_ready,
  output logic [`ST_RAM_AW-1:1] ram_addr_s, // scrambled, bit 23 dropped
  output logic       ram_cs
);

  logic [31:0] sd_wait; // cycles spent waiting
  logic coldboot_d; // for edge detect
  logic [1:0] scramble;

  // give the mcu time to mount a default image
  always_ff @(posedge clk32) begin
    if (rst) begin
      sd_wait  <= '0;
      sd_ready <= 1'b0;
    end else if (!sd_ready) begin
      if (sd_img_size != 32'd0) sd_ready <= 1'b1; // image is there
      if (sd_wait < 32'(sd_wait_cycles)) begin
        sd_wait <= sd_wait + 32'd1;
      end else begin
        sd_ready <= 1'b1; // gave up waiting, boot anyway
      end
    end
  end

  // step once per rising edge of the cold boot request
  always_ff @(posedge clk32) begin
    if (rst) begin
      coldboot_d <= 1'b0;
      scramble   <= 2'd0;
    end else begin
      coldboot_d <= coldboot;
      if (coldboot && !coldboot_d) scramble <= scramble + 2'd1;
    end
  end

  // every source of readiness, no pending reset
  assign core_run = sd_ready && ram_ready && flash_ready && !user_reset && !reset_req;

  // word address bits 4:3 xor scramble
  assign ram_addr_s = {ram_addr[`ST_RAM_AW-1:5], ram_addr[4:3] ^ scramble, ram_addr[2:1]};
  assign ram_cs     = !ram_ras_n && !ram_addr[`ST_RAM_AW]; // upper half is not ram

endmodule

// ==== verilog/input_mapper.sv ====
`timescale 1ns/1ns
`include "st_glue_defs.svh"

// mouse, joystick and keyboard glue between hid, db9 pins and the st
module input_mapper import st_glue_pkg::*; (
  input  logic [7:0]  io, // db9 pins, active low, 7:6 spare
  input  mouse_port_t mouse_port,
  input  joy_t        hid_mouse, // usb mouse
  input  logic [7:0]  hid_joy, // usb joystick, four buttons
  input  key_row_t    keyboard [`ST_KBD_ROWS], // matrix kept by hid
  input  logic [`ST_KBD_ROWS-1:0] kbd_col_sel, // low selects a row
  output joy_t        joy0, // st mouse port
  output logic [4:0]  joy1, // st joystick port
  output joy_t        db9_joy, // db9 used as joystick
  output key_row_t    kbd_rows // back to the ikbd
);

  joy_t db9_atari;
  joy_t db9_amiga;

  // pins are active low, reorder into fire2, fire, up, down, left, right
  // the two mice differ only in where the quadrature lines sit
  assign db9_atari = ~{io[5], io[0], io[2], io[1], io[4], io[3]};
  assign db9_amiga = ~{io[5], io[0], io[3], io[1], io[4], io[2]};

  // a db9 mouse replaces the usb mouse
  // mice hold some lines active, so they can't be ored together
  always_comb begin
    case (mouse_port)
      port_usb:   joy0 = hid_mouse;
      port_atari: joy0 = db9_atari;
      port_amiga: joy0 = db9_amiga;
      default:    joy0 = '0; // port off
    endcase
  end

  // db9 is a joystick only while the mouse is on usb
  assign db9_joy = (mouse_port == port_usb) ? db9_atari : '0;

  // joysticks are wired in parallel
  assign joy1 = hid_joy[4:0] | db9_joy[4:0];

  // ikbd drives a column pattern and reads back the rows
  // several selected rows combine like open drain lines
  always_comb begin
    kbd_rows = '1; // nothing pressed
    for (int r = 0; r < `ST_KBD_ROWS; r++) begin
      if (!kbd_col_sel[r]) kbd_rows &= keyboard[r];
    end
  end

endmodule

// ==== verilog/sd_request_arbiter.sv ====
`timescale 1ns/1ns
`include "st_glue_defs.svh"

// floppy and acsi share the single sd sector interface
// the sd controller takes start bits for all four drives at once,
// but only one sector number and one write byte
module sd_request_arbiter import st_glue_pkg::*; (
  input  logic      clk32,
  input  logic      rst,

  // floppy peer
  input  req_pair_t fdc_rd,
  input  req_pair_t fdc_wr,
  input  lba_t      fdc_lba,
  input  sd_byte_t  fdc_wr_byte,

  // acsi peer
  input  req_pair_t acsi_rd,
  input  req_pair_t acsi_wr,
  input  lba_t      acsi_lba,
  input  sd_byte_t  acsi_wr_byte,

  // toward the sd controller
  output logic [3:0] sd_rstart, // acsi in 3:2, floppy in 1:0
  output logic [3:0] sd_wstart,
  output lba_t      sd_lba,
  output sd_byte_t  sd_wr_byte
);

  logic fdc_req; // any floppy drive asking
  logic acsi_req; // any acsi drive asking
  logic acsi_owner; // acsi spoke last
  logic acsi_sel;

  assign fdc_req  = |{fdc_rd, fdc_wr};
  assign acsi_req = |{acsi_rd, acsi_wr};

  // requests drop once sd_busy shows, so the data phase after that
  // still needs to know who asked
  always_ff @(posedge clk32) begin
    if (rst) begin
      acsi_owner <= 1'b0;
    end else if (fdc_req) begin
      acsi_owner <= 1'b0; // floppy wins a tie
    end else if (acsi_req) begin
      acsi_owner <= 1'b1;
    end
  end

  // a live acsi request takes the bus right away
  assign acsi_sel = acsi_req | acsi_owner;

  // start bits go straight through, the controller picks the drive
  assign sd_rstart = {acsi_rd, fdc_rd};
  assign sd_wstart = {acsi_wr, fdc_wr};

  // sector number and outgoing byte from the owner
  always_comb begin
    if (acsi_sel) begin
      sd_lba     = acsi_lba;
      sd_wr_byte = acsi_wr_byte;
    end else begin
      sd_lba     = fdc_lba;
      sd_wr_byte = fdc_wr_byte;
    end
  end

endmodule

// ==== verilog/st_glue.sv ====
`timescale 1ns/1ns
`include "st_glue_defs.svh"

// glue between the st chipset, the sd card, boot sources and the osd
module st_glue import st_glue_pkg::*; #(
  parameter int unsigned sd_wait_cycles = `ST_SD_WAIT_CYCLES
) (
  input  logic        clk32,
  input  logic        rst,

  // sd sector peers
  input  req_pair_t   fdc_rd,
  input  req_pair_t   fdc_wr,
  input  lba_t        fdc_lba,
  input  sd_byte_t    fdc_wr_byte,
  input  req_pair_t   acsi_rd,
  input  req_pair_t   acsi_wr,
  input  lba_t        acsi_lba,
  input  sd_byte_t    acsi_wr_byte,
  output logic [3:0]  sd_rstart,
  output logic [3:0]  sd_wstart,
  output lba_t        sd_lba,
  output sd_byte_t    sd_wr_byte,

  // boot and ram
  input  logic        reset_req,
  input  logic        coldboot,
  input  logic        user_reset,
  input  logic        ram_ready,
  input  logic        flash_ready,
  input  logic [31:0] sd_img_size,
  input  ram_addr_t   ram_addr,
  input  logic        ram_ras_n,
  output logic        core_run,
  output logic        sd_ready,
  output logic [`ST_RAM_AW-1:1] ram_addr_s,
  output logic        ram_cs,

  // inputs
  input  logic [7:0]  io,
  input  mouse_port_t mouse_port,
  input  joy_t        hid_mouse,
  input  logic [7:0]  hid_joy,
  input  key_row_t    keyboard [`ST_KBD_ROWS],
  input  logic [`ST_KBD_ROWS-1:0] kbd_col_sel,
  output joy_t        joy0,
  output logic [4:0]  joy1,
  output joy_t        db9_joy,
  output key_row_t    kbd_rows,

  // audio
  input  volume_t     volume,
  input  sample_in_t  audio_l_in,
  input  sample_in_t  audio_r_in,
  output sample_t     audio_l,
  output sample_t     audio_r
);

  sd_request_arbiter u_arbiter (
    .clk32(clk32),
    .rst(rst),
    .fdc_rd(fdc_rd),
    .fdc_wr(fdc_wr),
    .fdc_lba(fdc_lba),
    .fdc_wr_byte(fdc_wr_byte),
    .acsi_rd(acsi_rd),
    .acsi_wr(acsi_wr),
    .acsi_lba(acsi_lba),
    .acsi_wr_byte(acsi_wr_byte),
    .sd_rstart(sd_rstart),
    .sd_wstart(sd_wstart),
    .sd_lba(sd_lba),
    .sd_wr_byte(sd_wr_byte)
  );

  boot_control #(
    .sd_wait_cycles(sd_wait_cycles)
  ) u_boot (
    .clk32(clk32),
    .rst(rst),
    .reset_req(reset_req),
    .coldboot(coldboot),
    .user_reset(user_reset),
    .ram_ready(ram_ready),
    .flash_ready(flash_ready),
    .sd_img_size(sd_img_size),
    .ram_addr(ram_addr),
    .ram_ras_n(ram_ras_n),
    .core_run(core_run),
    .sd_ready(sd_ready),
    .ram_addr_s(ram_addr_s),
    .ram_cs(ram_cs)
  );

  input_mapper u_input (
    .io(io),
    .mouse_port(mouse_port),
    .hid_mouse(hid_mouse),
    .hid_joy(hid_joy),
    .keyboard(keyboard),
    .kbd_col_sel(kbd_col_sel),
    .joy0(joy0),
    .joy1(joy1),
    .db9_joy(db9_joy),
    .kbd_rows(kbd_rows)
  );

  audio_volume u_audio (
    .volume(volume),
    .audio_l_in(audio_l_in),
    .audio_r_in(audio_r_in),
    .audio_l(audio_l),
    .audio_r(audio_r)
  );

endmodule

// ==== verilog/st_glue_pkg.sv ====
`include "st_glue_defs.svh"

package st_glue_pkg;

  // sd sector interface
  typedef logic [`ST_LBA_W-1:0] lba_t; // sector number
  typedef logic [7:0] sd_byte_t; // one sector byte
  typedef logic [1:0] req_pair_t; // one request per drive

  // ram word address, bits 23:1
  typedef logic [`ST_RAM_AW:1] ram_addr_t;

  // fire2, fire, up, down, left, right
  typedef logic [5:0] joy_t;

  // one keyboard row, low = key down
  typedef logic [7:0] key_row_t;

  // audio samples
  typedef logic signed [`ST_AUDIO_IN_W-1:0] sample_in_t; // chipset mix
  typedef logic signed [15:0] sample_t; // dac side

  // osd mouse port setting
  typedef enum logic [1:0] {
    port_usb, // hid mouse, db9 free for joystick
    port_atari, // db9 mouse in atari pin order
    port_amiga, // db9 mouse in amiga pin order
    port_none
  } mouse_port_t;

  // osd volume setting
  typedef enum logic [1:0] {
    vol_mute,
    vol_quarter,
    vol_half,
    vol_full
  } volume_t;

endpackage
